// ==== logic/backend.sv ====
module backend (
    input  logic                               clk,
    input  logic                               rst_n_i,

    // fetch side
    input  logic                               valid_i,
    input  logic [backend_pkg::xlen-1:0]       pc_i,
    input  logic [backend_pkg::inst_width-1:0] inst_i,
    input  logic                               flush_i,

    // retire side
    output logic                               commit_valid_o,
    output backend_pkg::commit_t               commit_o
);

    // decoder to dispatch
    logic                                   dec_valid;
    backend_pkg::decoded_t                  dec;

    // dispatch and register file
    logic [backend_pkg::reg_addr_width-1:0] rd_addr0;
    logic [backend_pkg::reg_addr_width-1:0] rd_addr1;
    logic [backend_pkg::xlen-1:0]           rd_data0;
    logic [backend_pkg::xlen-1:0]           rd_data1;

    // dispatch to execute
    logic                                   iss_valid;
    backend_pkg::issued_t                   iss;

    // forwarding and writeback
    backend_pkg::reg_write_t                ex_fwd;
    backend_pkg::reg_write_t                wb_write;    // also feeds the array

    decoder u_decoder (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .valid_i     (valid_i),
        .pc_i        (pc_i),
        .inst_i      (inst_i),
        .dec_valid_o (dec_valid),
        .dec_o       (dec)
    );

    dispatch u_dispatch (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .dec_valid_i (dec_valid),
        .dec_i       (dec),
        .rd_data0_i  (rd_data0),
        .rd_data1_i  (rd_data1),
        .ex_fwd_i    (ex_fwd),
        .wb_fwd_i    (wb_write),
        .rd_addr0_o  (rd_addr0),
        .rd_addr1_o  (rd_addr1),
        .iss_valid_o (iss_valid),
        .iss_o       (iss)
    );

    reg_files u_reg_files (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rd_addr0_i (rd_addr0),
        .rd_addr1_i (rd_addr1),
        .wr_i       (wb_write),
        .rd_data0_o (rd_data0),
        .rd_data1_o (rd_data1)
    );

    execute u_execute (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .iss_valid_i    (iss_valid),
        .iss_i          (iss),
        .ex_fwd_o       (ex_fwd),
        .wb_o           (wb_write),
        .commit_valid_o (commit_valid_o),
        .commit_o       (commit_o)
    );

endmodule

// ==== logic/backend_pkg.sv ====
package backend_pkg;

    localparam int xlen           = 32;
    localparam int inst_width     = 32;
    localparam int reg_addr_width = 5;
    localparam int reg_count      = 32;

    // 3R format, inst[31:15]
    localparam logic [16:0] op_add_w = 17'h00020;
    localparam logic [16:0] op_sub_w = 17'h00022;
    localparam logic [16:0] op_and   = 17'h00029;
    localparam logic [16:0] op_or    = 17'h0002a;
    localparam logic [16:0] op_xor   = 17'h0002b;

    // 2RI12 format, inst[31:22]
    localparam logic [9:0]  op_addi_w = 10'h00a;

    // 1RI20 format, inst[31:25]
    localparam logic [6:0]  op_lu12i_w = 7'h0a;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4,
        alu_imm = 3'd5    // pass the immediate through
    } alu_op_e;

    typedef enum logic {
        sel_reg = 1'b0,
        sel_imm = 1'b1
    } alu_sel_e;

    typedef struct packed {
        logic [xlen-1:0]           pc;
        alu_op_e                   alu_op;
        alu_sel_e                  alu_sel;
        logic [reg_addr_width-1:0] rj;
        logic                      rj_re;
        logic [reg_addr_width-1:0] rk;
        logic                      rk_re;
        logic [reg_addr_width-1:0] rd;
        logic [xlen-1:0]           imm;    // already extended or shifted
    } decoded_t;

    typedef struct packed {
        logic [xlen-1:0]           pc;
        alu_op_e                   alu_op;
        logic [reg_addr_width-1:0] rd;
        logic [xlen-1:0]           op0;
        logic [xlen-1:0]           op1;    // register or immediate
    } issued_t;

    typedef struct packed {
        logic                      we;
        logic [reg_addr_width-1:0] addr;
        logic [xlen-1:0]           data;
    } reg_write_t;

    typedef struct packed {
        logic [xlen-1:0]           pc;
        logic [reg_addr_width-1:0] rd;
        logic [xlen-1:0]           result;
    } commit_t;

endpackage

// ==== logic/decoder.sv ====
module decoder (
    input  logic                               clk,
    input  logic                               rst_n_i,
    input  logic                               flush_i,
    input  logic                               valid_i,
    input  logic [backend_pkg::xlen-1:0]       pc_i,
    input  logic [backend_pkg::inst_width-1:0] inst_i,
    output logic                               dec_valid_o,
    output backend_pkg::decoded_t              dec_o
);

    logic [16:0]           opc17;
    logic [9:0]            opc10;
    logic [6:0]            opc7;
    logic                  supported;
    backend_pkg::decoded_t dec_d;
    logic                  dec_valid_q;
    backend_pkg::decoded_t dec_q;

    assign opc17 = inst_i[31:15];
    assign opc10 = inst_i[31:22];
    assign opc7  = inst_i[31:25];

    always_comb begin
        dec_d         = '0;
        dec_d.pc      = pc_i;
        dec_d.rd      = inst_i[4:0];
        dec_d.rj      = inst_i[9:5];
        dec_d.rk      = inst_i[14:10];
        dec_d.alu_op  = backend_pkg::alu_add;
        dec_d.alu_sel = backend_pkg::sel_reg;
        supported     = 1'b1;

        if (opc17 == backend_pkg::op_add_w || opc17 == backend_pkg::op_sub_w ||
            opc17 == backend_pkg::op_and   || opc17 == backend_pkg::op_or    ||
            opc17 == backend_pkg::op_xor) begin
            dec_d.rj_re = 1'b1;    // both sources from registers
            dec_d.rk_re = 1'b1;
            case (opc17)
                backend_pkg::op_sub_w: dec_d.alu_op = backend_pkg::alu_sub;
                backend_pkg::op_and:   dec_d.alu_op = backend_pkg::alu_and;
                backend_pkg::op_or:    dec_d.alu_op = backend_pkg::alu_or;
                backend_pkg::op_xor:   dec_d.alu_op = backend_pkg::alu_xor;
                default:               dec_d.alu_op = backend_pkg::alu_add;
            endcase
        end else if (opc10 == backend_pkg::op_addi_w) begin
            dec_d.rj_re   = 1'b1;
            dec_d.alu_sel = backend_pkg::sel_imm;
            dec_d.imm     = {{20{inst_i[21]}}, inst_i[21:10]};    // si12
        end else if (opc7 == backend_pkg::op_lu12i_w) begin
            dec_d.alu_op  = backend_pkg::alu_imm;
            dec_d.alu_sel = backend_pkg::sel_imm;
            dec_d.imm     = {inst_i[24:5], 12'b0};    // si20 << 12
        end else begin
            supported = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            dec_valid_q <= 1'b0;
        end else begin
            dec_valid_q <= valid_i && supported && !flush_i;    // unknown encodings drop here
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i) begin
            dec_q <= dec_d;
        end
    end

    assign dec_valid_o = dec_valid_q;
    assign dec_o       = dec_q;

    // an issued micro-op must carry a legal operation
    a_dec_op_known: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        dec_valid_o |-> !$isunknown(dec_o.alu_op) &&
                        dec_o.alu_op inside {backend_pkg::alu_add, backend_pkg::alu_sub,
                                             backend_pkg::alu_and, backend_pkg::alu_or,
                                             backend_pkg::alu_xor, backend_pkg::alu_imm}
    );

endmodule

// ==== logic/dispatch.sv ====
module dispatch (
    input  logic                                   clk,
    input  logic                                   rst_n_i,
    input  logic                                   flush_i,
    input  logic                                   dec_valid_i,
    input  backend_pkg::decoded_t                  dec_i,
    input  logic [backend_pkg::xlen-1:0]           rd_data0_i,
    input  logic [backend_pkg::xlen-1:0]           rd_data1_i,
    input  backend_pkg::reg_write_t                ex_fwd_i,
    input  backend_pkg::reg_write_t                wb_fwd_i,
    output logic [backend_pkg::reg_addr_width-1:0] rd_addr0_o,
    output logic [backend_pkg::reg_addr_width-1:0] rd_addr1_o,
    output logic                                   iss_valid_o,
    output backend_pkg::issued_t                   iss_o
);

    logic [backend_pkg::xlen-1:0] src0;
    logic [backend_pkg::xlen-1:0] src1;
    backend_pkg::issued_t         iss_d;
    logic                         iss_valid_q;
    backend_pkg::issued_t         iss_q;

    // youngest producer wins, then commit stage, then the array
    function automatic logic [backend_pkg::xlen-1:0] resolve(
        input logic [backend_pkg::reg_addr_width-1:0] addr,
        input logic [backend_pkg::xlen-1:0]           rf_data,
        input backend_pkg::reg_write_t                ex_w,
        input backend_pkg::reg_write_t                wb_w
    );
        logic [backend_pkg::xlen-1:0] val;
        if (addr == '0) begin
            val = '0;
        end else if (ex_w.we && ex_w.addr == addr) begin
            val = ex_w.data;
        end else if (wb_w.we && wb_w.addr == addr) begin
            val = wb_w.data;
        end else begin
            val = rf_data;
        end
        return val;
    endfunction

    // unused source reads r0 so it resolves to zero
    assign rd_addr0_o = dec_i.rj_re ? dec_i.rj : '0;
    assign rd_addr1_o = dec_i.rk_re ? dec_i.rk : '0;

    assign src0 = resolve(rd_addr0_o, rd_data0_i, ex_fwd_i, wb_fwd_i);
    assign src1 = resolve(rd_addr1_o, rd_data1_i, ex_fwd_i, wb_fwd_i);

    always_comb begin
        iss_d.pc     = dec_i.pc;
        iss_d.alu_op = dec_i.alu_op;
        iss_d.rd     = dec_i.rd;
        iss_d.op0    = src0;
        iss_d.op1    = (dec_i.alu_sel == backend_pkg::sel_imm) ? dec_i.imm : src1;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            iss_valid_q <= 1'b0;
        end else begin
            iss_valid_q <= dec_valid_i && !flush_i;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid_i) begin
            iss_q <= iss_d;
        end
    end

    assign iss_valid_o = iss_valid_q;
    assign iss_o       = iss_q;

endmodule

// ==== logic/execute.sv ====
module execute (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    flush_i,
    input  logic                    iss_valid_i,
    input  backend_pkg::issued_t    iss_i,
    output backend_pkg::reg_write_t ex_fwd_o,
    output backend_pkg::reg_write_t wb_o,
    output logic                    commit_valid_o,
    output backend_pkg::commit_t    commit_o
);

    logic [backend_pkg::xlen-1:0] result;
    logic                         commit_valid_q;
    backend_pkg::commit_t         commit_q;

    always_comb begin
        unique case (iss_i.alu_op)
            backend_pkg::alu_add: result = iss_i.op0 + iss_i.op1;    // wraps at 32 bits
            backend_pkg::alu_sub: result = iss_i.op0 - iss_i.op1;
            backend_pkg::alu_and: result = iss_i.op0 & iss_i.op1;
            backend_pkg::alu_or:  result = iss_i.op0 | iss_i.op1;
            backend_pkg::alu_xor: result = iss_i.op0 ^ iss_i.op1;
            backend_pkg::alu_imm: result = iss_i.op1;
            default:              result = '0;
        endcase
    end

    // every supported op writes rd
    assign ex_fwd_o.we   = iss_valid_i;
    assign ex_fwd_o.addr = iss_i.rd;
    assign ex_fwd_o.data = result;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            commit_valid_q <= 1'b0;
        end else begin
            commit_valid_q <= iss_valid_i && !flush_i;
        end
    end

    always_ff @(posedge clk) begin
        if (iss_valid_i) begin
            commit_q.pc     <= iss_i.pc;
            commit_q.rd     <= iss_i.rd;
            commit_q.result <= result;
        end
    end

    assign commit_valid_o = commit_valid_q;
    assign commit_o       = commit_q;

    assign wb_o.we   = commit_valid_q;    // array write lands on the next edge
    assign wb_o.addr = commit_q.rd;
    assign wb_o.data = commit_q.result;

    a_wb_matches_commit: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        wb_o.we == commit_valid_o
    );

endmodule

// ==== logic/reg_files.sv ====
module reg_files (
    input  logic                                   clk,
    input  logic                                   rst_n_i,
    input  logic [backend_pkg::reg_addr_width-1:0] rd_addr0_i,
    input  logic [backend_pkg::reg_addr_width-1:0] rd_addr1_i,
    input  backend_pkg::reg_write_t                wr_i,
    output logic [backend_pkg::xlen-1:0]           rd_data0_o,
    output logic [backend_pkg::xlen-1:0]           rd_data1_o
);

    logic [backend_pkg::xlen-1:0] regs [backend_pkg::reg_count];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < backend_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.we && wr_i.addr != '0) begin    // r0 is hardwired
            regs[wr_i.addr] <= wr_i.data;
        end
    end

    // async read, same-cycle writes are covered by forwarding
    assign rd_data0_o = regs[rd_addr0_i];
    assign rd_data1_o = regs[rd_addr1_i];

    a_r0_zero: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        regs[0] == '0
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build the backend testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert --top-module backend_tb -f sources.f \
    -o backend_sim > build.log 2>&1 \
    && ./obj_dir/backend_sim > sim.log 2>&1 \
    || { cat build.log; echo "build or simulation run did not complete"; exit 1; }
cat sim.log
grep -q "Testbench failed" sim.log && exit 1 || exit 0

// ==== sources.f ====
logic/backend_pkg.sv
logic/decoder.sv
logic/reg_files.sv
logic/dispatch.sv
logic/execute.sv
logic/backend.sv
testbench/backend_tb.sv

// ==== testbench/backend_tb.sv ====
module backend_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_period  = 8;
    localparam int inst_total  = 65;    // instructions sent over all tests
    localparam int watchdog_ns = (10 + inst_total * 4 + 200) * clk_period;

    typedef enum logic [2:0] {k_add, k_sub, k_and, k_or, k_xor, k_addi, k_lu12i, k_bad} kind_e;

    logic                 clk;
    logic                 rst_n;
    logic                 valid;
    logic                 flush;
    logic [31:0]          pc;
    logic [31:0]          inst;
    logic                 commit_valid;
    backend_pkg::commit_t commit;

    logic [31:0]          model_regs [32];    // reference register state
    backend_pkg::commit_t exp_q [$];
    int                   cycle_q [$];        // cycle in which each commit is due
    logic [31:0]          lfsr_state;
    logic [31:0]          next_pc;
    int                   cycle;
    int                   errors;
    int                   checks;
    int                   tests_run;

    backend i_backend (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .valid_i        (valid),
        .pc_i           (pc),
        .inst_i         (inst),
        .flush_i        (flush),
        .commit_valid_o (commit_valid),
        .commit_o       (commit)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        cycle = 0;
        forever begin
            @(posedge clk);
            cycle++;
        end
    end

    initial begin
        #(watchdog_ns);
        $display("timeout after %0d ns, the DUT stopped committing", watchdog_ns);
        $display("Testbench failed");
        $finish;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) n = n ^ 32'hA300_0000;    // galois taps
        return n;
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]};    // one step per bit
        end
    endtask

    function automatic logic [31:0] encode(input kind_e kind, input logic [4:0] rd,
                                           input logic [4:0] rj, input logic [4:0] rk,
                                           input logic [19:0] imm);
        logic [31:0] enc;
        case (kind)
            k_add:   enc = {backend_pkg::op_add_w, rk, rj, rd};
            k_sub:   enc = {backend_pkg::op_sub_w, rk, rj, rd};
            k_and:   enc = {backend_pkg::op_and, rk, rj, rd};
            k_or:    enc = {backend_pkg::op_or, rk, rj, rd};
            k_xor:   enc = {backend_pkg::op_xor, rk, rj, rd};
            k_addi:  enc = {backend_pkg::op_addi_w, imm[11:0], rj, rd};
            k_lu12i: enc = {backend_pkg::op_lu12i_w, imm, rd};
            default: enc = {7'h7e, imm, rd};    // matches no prefix
        endcase
        return enc;
    endfunction

    function automatic logic [31:0] model_result(input kind_e kind, input logic [31:0] a,
                                                 input logic [31:0] b, input logic [19:0] imm);
        logic [31:0] res;
        case (kind)
            k_add:   res = a + b;
            k_sub:   res = a - b;
            k_and:   res = a & b;
            k_or:    res = a | b;
            k_xor:   res = a ^ b;
            k_addi:  res = a + {{20{imm[11]}}, imm[11:0]};
            default: res = {imm, 12'h000};
        endcase
        return res;
    endfunction

    task automatic check_commit(input backend_pkg::commit_t got, input backend_pkg::commit_t exp,
                                input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0d ns: %s got pc %h rd %0d res %h, want pc %h rd %0d res %h",
                     $time, what, got.pc, got.rd, got.result, exp.pc, exp.rd, exp.result);
        end
    endtask

    task automatic check_valid(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0d ns: %s got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_cycle(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("Fail at %0d ns: %s got cycle %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // commit monitor, samples away from the active edge
    initial begin
        backend_pkg::commit_t exp;
        int                   due;
        forever begin
            @(negedge clk);
            if (rst_n && commit_valid) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("unexpected commit of pc %h at %0d ns with nothing outstanding",
                             commit.pc, $time);
                end else begin
                    exp = exp_q.pop_front();
                    due = cycle_q.pop_front();
                    check_commit(commit, exp, "commit record");
                    check_cycle(cycle, due, "commit latency");
                end
            end
        end
    end

    task automatic send(input kind_e kind, input logic [4:0] rd, input logic [4:0] rj,
                        input logic [4:0] rk, input logic [19:0] imm, input bit track);
        backend_pkg::commit_t exp;
        @(negedge clk);
        valid = 1'b1;
        pc    = next_pc;
        inst  = encode(kind, rd, rj, rk, imm);
        if (track && kind != k_bad) begin
            exp.pc     = next_pc;
            exp.rd     = rd;
            exp.result = model_result(kind, model_regs[rj], model_regs[rk], imm);
            exp_q.push_back(exp);
            cycle_q.push_back(cycle + 3);    // sampled next edge, commits two later
            if (rd != 5'd0) model_regs[rd] = exp.result;
        end
        next_pc = next_pc + 32'd4;
    endtask

    task automatic wait_drain;
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 20) begin
            @(negedge clk);
            valid = 1'b0;
            n++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("pipeline did not drain, %0d commits still missing at %0d ns",
                     exp_q.size(), $time);
            exp_q.delete();
            cycle_q.delete();
        end
    endtask

    task automatic report_test(input string name, input int e0);
        tests_run++;
        $display("%s: %s, %0d errors", name, (errors == e0) ? "ok" : "mismatch", errors - e0);
    endtask

    task automatic test_idle_after_reset;
        int e0;
        e0 = errors;
        repeat (20) begin
            @(negedge clk);
            valid = 1'b0;
            check_valid(commit_valid, 1'b0, "commit while idle");
        end
        report_test("idle after reset", e0);
    endtask

    task automatic test_build_constants;
        int          e0;
        logic [31:0] r;
        logic [31:0] lo;
        logic [4:0]  rd;
        e0 = errors;
        rd = 5'd0;
        repeat (8) begin
            rd = rd + 5'd1;
            draw_bits(20, r);
            draw_bits(12, lo);
            send(k_lu12i, rd, 5'd0, 5'd0, r[19:0], 1'b1);
            send(k_addi, rd, rd, 5'd0, {8'h00, lo[11:0]}, 1'b1);    // reads rd one back
        end
        wait_drain();
        report_test("lu12i.w and addi.w constants", e0);
    endtask

    task automatic test_forwarding_chain;
        int          e0;
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  hist [$];    // newest at the back
        kind_e       kind;
        e0 = errors;
        hist = '{5'd1, 5'd2, 5'd3};
        for (int i = 0; i < 30; i++) begin
            case (i % 5)
                0:       kind = k_add;
                1:       kind = k_sub;
                2:       kind = k_and;
                3:       kind = k_or;
                default: kind = k_xor;
            endcase
            draw_bits(4, r);
            rd = {1'b0, r[3:0]} + 5'd1;
            // sources rotate over distances 1, 2 and 3
            send(kind, rd, hist[2 - (i % 3)], hist[(4 - (i % 3)) % 3], 20'h0, 1'b1);
            void'(hist.pop_front());
            hist.push_back(rd);
        end
        wait_drain();
        report_test("forwarding chain", e0);
    endtask

    task automatic test_r0_writes;
        int e0;
        e0 = errors;
        send(k_addi, 5'd0, 5'd1, 5'd0, 20'h007ff, 1'b1);
        send(k_lu12i, 5'd0, 5'd0, 5'd0, 20'habcde, 1'b1);
        send(k_add, 5'd9, 5'd0, 5'd0, 20'h0, 1'b1);    // r0 still in execute
        send(k_or, 5'd10, 5'd0, 5'd2, 20'h0, 1'b1);
        send(k_xor, 5'd11, 5'd2, 5'd0, 20'h0, 1'b1);
        wait_drain();
        report_test("writes to r0", e0);
    endtask

    task automatic test_unsupported_drop;
        int          e0;
        logic [31:0] r;
        e0 = errors;
        draw_bits(20, r);
        send(k_add, 5'd12, 5'd1, 5'd2, 20'h0, 1'b1);
        send(k_bad, 5'd13, 5'd0, 5'd0, r[19:0], 1'b1);
        send(k_sub, 5'd13, 5'd12, 5'd3, 20'h0, 1'b1);
        send(k_bad, 5'd14, 5'd0, 5'd0, ~r[19:0], 1'b1);
        send(k_bad, 5'd1, 5'd0, 5'd0, r[19:0], 1'b1);
        send(k_xor, 5'd14, 5'd13, 5'd12, 20'h0, 1'b1);
        send(k_or, 5'd15, 5'd14, 5'd1, 20'h0, 1'b1);
        wait_drain();
        report_test("unsupported instructions", e0);
    endtask

    task automatic test_flush_in_flight;
        int e0;
        e0 = errors;
        send(k_lu12i, 5'd20, 5'd0, 5'd0, 20'h5a5a5, 1'b1);
        wait_drain();
        send(k_addi, 5'd20, 5'd20, 5'd0, 20'h00123, 1'b0);    // never reaches the model
        send(k_lu12i, 5'd21, 5'd0, 5'd0, 20'h12345, 1'b0);
        send(k_add, 5'd22, 5'd1, 5'd2, 20'h0, 1'b0);
        flush = 1'b1;    // same edge as the third strobe
        @(negedge clk);
        valid = 1'b0;
        flush = 1'b0;
        repeat (6) begin
            @(negedge clk);
            check_valid(commit_valid, 1'b0, "commit after flush");
        end
        send(k_add, 5'd23, 5'd20, 5'd21, 20'h0, 1'b1);
        send(k_or, 5'd24, 5'd20, 5'd22, 20'h0, 1'b1);
        send(k_addi, 5'd25, 5'd21, 5'd0, 20'h00001, 1'b1);
        wait_drain();
        report_test("flush in flight", e0);
    endtask

    initial begin
        rst_n      = 1'b0;
        valid      = 1'b0;
        flush      = 1'b0;
        pc         = '0;
        inst       = '0;
        next_pc    = 32'h1c00_0000;
        lfsr_state = 32'd97;
        errors     = 0;
        checks     = 0;
        tests_run  = 0;
        model_regs = '{default: '0};
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_idle_after_reset();
        test_build_constants();
        test_forwarding_chain();
        test_r0_writes();
        test_unsupported_drop();
        test_flush_in_flight();

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
